// File: bench/ext_mem_model.sv
////////////////////
// Bus-side memory model for the testbench
// Acks each request after a delay that the testbench supplies
////////////////////
`timescale 1ns/1ps

module ext_mem_model (
    input  logic              clk,
    input  logic              rst,
    input  logic [1:0]        ack_delay,
    input  lsu_pkg::bus_req_t bus_req,
    input  logic              bus_valid,
    output logic              bus_ack,
    output logic [31:0]       bus_rdata
);

    // Sixteen words, enough for the bus window the testbench uses
    logic [31:0] mem [16];
    logic        counting;
    logic [1:0]  wait_cnt;
    logic [3:0]  idx;

    assign idx = bus_req.addr[5:2];

    always @(posedge clk) begin
        if (rst) begin
            bus_ack   <= 1'b0;
            bus_rdata <= 32'h0;
            counting  <= 1'b0;
            wait_cnt  <= 2'd0;
        end else begin
            bus_ack   <= 1'b0;
            bus_rdata <= 32'h0;
            // New request, skip the cycle of our own ack
            if (bus_valid && !bus_ack && !counting) begin
                counting <= 1'b1;
                wait_cnt <= ack_delay;
            end else if (counting) begin
                if (wait_cnt == 2'd0) begin
                    counting  <= 1'b0;
                    bus_ack   <= 1'b1;
                    bus_rdata <= mem[idx];
                    for (int i = 0; i < 4; i++) begin
                        if (bus_req.write && bus_req.be[i])
                            mem[idx][i*8 +: 8] <= bus_req.wdata[i*8 +: 8];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

// File: bench/lsu_tb.sv
////////////////////
// Testbench for the load/store unit top level
// Reference models are updated at issue and concurrent assertions check outputs
////////////////////
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

    localparam int LIMIT = 300;

    logic                  clk;
    logic                  rst;
    logic                  issue_valid;
    lsu_pkg::ls_request_t  issue_req;
    logic                  issue_ready;
    lsu_pkg::wb_t          wb;
    lsu_pkg::ls_exc_t      exc;
    lsu_pkg::bus_req_t     bus_req;
    logic                  bus_valid;
    logic                  bus_ack;
    logic [31:0]           bus_rdata;
    logic [1:0]            ack_delay;

    ////////////////////
    // Reference state

    // Bytes indexed by {region, word, offset}
    logic [7:0]            ref_mem [128];
    logic [31:0]           last_load;
    logic [`LSU_ID_W-1:0]  next_id;
    logic [15:0]           lfsr;

    // Expected writebacks in issue order
    logic [`LSU_ID_W-1:0]  exp_id [64];
    logic                  exp_load [64];
    logic [31:0]           exp_data [64];
    logic [5:0]            exp_wr;
    logic [5:0]            exp_rd;

    // Expected misalignment reports
    logic [`LSU_ID_W-1:0]  exc_id [64];
    logic [31:0]           exc_addr [64];
    logic                  exc_store [64];
    logic [5:0]            exc_wr;
    logic [5:0]            exc_rd;

    // Expected bus requests
    logic [31:0]           bus_addr [64];
    logic [3:0]            bus_be [64];
    logic [31:0]           bus_wdata [64];
    logic                  bus_write [64];
    logic [5:0]            bus_wr;
    logic [5:0]            bus_rd;

    lsu_top UUT (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_ready (issue_ready),
        .wb          (wb),
        .exc         (exc),
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata)
    );

    ext_mem_model ext_mem (
        .clk       (clk),
        .rst       (rst),
        .ack_delay (ack_delay),
        .bus_req   (bus_req),
        .bus_valid (bus_valid),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // Helpers

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [2:0] pick_fn(input logic [2:0] r);
        case (r)
            3'd0:    return `LSU_FN_B;
            3'd1:    return `LSU_FN_BU;
            3'd2:    return `LSU_FN_H;
            3'd3:    return `LSU_FN_HU;
            default: return `LSU_FN_W;
        endcase
    endfunction

    // Live byte lanes for a store of the given size
    function automatic logic [3:0] expected_be(input logic [1:0] size, input logic [1:0] off);
        case (size)
            2'd0:    return 4'b0001 << off;
            2'd1:    return off[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // Store data copied into every lane
    function automatic logic [31:0] lane_copy(input logic [1:0] size, input logic [31:0] d);
        case (size)
            2'd0:    return {d[7:0], d[7:0], d[7:0], d[7:0]};
            2'd1:    return {d[15:0], d[15:0]};
            default: return d;
        endcase
    endfunction

    // Reference bytes followed by sign or zero extension
    function automatic logic [31:0] load_value(input logic [2:0] fn3, input logic [6:0] idx);
        logic [31:0] v;
        case (fn3[1:0])
            2'd0:    v = {24'h0, ref_mem[idx]};
            2'd1:    v = {16'h0, ref_mem[7'(idx + 1)], ref_mem[idx]};
            default: v = {ref_mem[7'(idx + 3)], ref_mem[7'(idx + 2)],
                          ref_mem[7'(idx + 1)], ref_mem[idx]};
        endcase
        if (fn3 == `LSU_FN_B)
            v = {{24{v[7]}}, v[7:0]};
        else if (fn3 == `LSU_FN_H)
            v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    ////////////////////
    // Issue one request and record what must come back

    task automatic issue_one(input logic [2:0] fn3, input logic is_load, input logic fwd,
                             input logic region, input logic [3:0] word,
                             input logic [1:0] off, input logic [31:0] data);
        lsu_pkg::ls_request_t req;
        logic [31:0]          addr;
        logic [6:0]           idx;
        logic                 misal;
        logic [31:0]          value;
        logic [3:0]           be;
        logic [31:0]          lanes;
        int                   waited;
        waited = 0;
        @(posedge clk);
        while (!issue_ready && waited < LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!issue_ready)
            stop_run("Input buffer never accepted a new request");
        addr  = {region ? 26'h040_0000 : 26'h0, word, off};
        idx   = {region, word, off};
        misal = (fn3[1:0] == 2'd1 && off[0]) || (fn3[1:0] == 2'd2 && off != 2'd0);
        value = (fwd && !is_load) ? last_load : data;
        be    = expected_be(fn3[1:0], off);
        lanes = lane_copy(fn3[1:0], value);
        if (misal) begin
            exc_id[exc_wr]    = next_id;
            exc_addr[exc_wr]  = addr;
            exc_store[exc_wr] = !is_load;
            exc_wr            = exc_wr + 1'b1;
        end else begin
            if (is_load) begin
                value     = load_value(fn3, idx);
                last_load = value;
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i])
                        ref_mem[{idx[6:2], 2'(i)}] = lanes[i*8 +: 8];
                end
            end
            exp_id[exp_wr]   = next_id;
            exp_load[exp_wr] = is_load;
            exp_data[exp_wr] = value;
            exp_wr           = exp_wr + 1'b1;
            if (region) begin
                bus_addr[bus_wr]  = {addr[31:2], 2'b00};
                bus_be[bus_wr]    = is_load ? 4'b0000 : be;
                bus_wdata[bus_wr] = lanes;
                bus_write[bus_wr] = !is_load;
                bus_wr            = bus_wr + 1'b1;
            end
        end
        req.fn3      = fn3;
        req.is_load  = is_load;
        req.is_store = !is_load;
        req.forward  = fwd;
        req.addr     = addr;
        req.data     = data;
        req.id       = next_id;
        next_id      = next_id + 1'b1;
        issue_valid <= 1'b1;
        issue_req   <= req;
        ack_delay   <= 2'(random_bits(2));
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((exp_rd != exp_wr || exc_rd != exc_wr || bus_rd != bus_wr) && waited < LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd != exp_wr || exc_rd != exc_wr || bus_rd != bus_wr)
            stop_run("Outstanding results never arrived");
    endtask

    // Retire expectations as the DUT reports them
    always @(posedge clk) begin
        if (rst) begin
            exp_rd <= '0;
            exc_rd <= '0;
            bus_rd <= '0;
        end else begin
            if (wb.done)
                exp_rd <= exp_rd + 1'b1;
            if (exc.valid)
                exc_rd <= exc_rd + 1'b1;
            if (bus_valid && bus_ack)
                bus_rd <= bus_rd + 1'b1;
        end
    end

    ////////////////////
    // Checks

    wb_in_order: assert property (@(posedge clk) disable iff (rst)
        wb.done |-> (exp_rd != exp_wr) && (wb.id == exp_id[exp_rd]))
        else stop_run($sformatf("FAIL %0t: writeback id %0h out of issue order",
                                $time, $sampled(wb.id)));

    wb_load_data: assert property (@(posedge clk) disable iff (rst)
        (wb.done && exp_load[exp_rd]) |-> (wb.data == exp_data[exp_rd]))
        else stop_run($sformatf("FAIL %0t: load id %0h returned %08h",
                                $time, $sampled(wb.id), $sampled(wb.data)));

    exc_report: assert property (@(posedge clk) disable iff (rst)
        exc.valid |-> (exc_rd != exc_wr) && (exc.id == exc_id[exc_rd])
                      && (exc.addr == exc_addr[exc_rd])
                      && (exc.is_store == exc_store[exc_rd]))
        else stop_run($sformatf("FAIL %0t: misaligned report id %0h addr %08h store %0b",
                                $time, $sampled(exc.id), $sampled(exc.addr),
                                $sampled(exc.is_store)));

    bus_request: assert property (@(posedge clk) disable iff (rst)
        (bus_valid && bus_ack) |-> (bus_rd != bus_wr) && (bus_req.addr == bus_addr[bus_rd])
            && (bus_req.write == bus_write[bus_rd]) && (!bus_req.write
            || (bus_req.be == bus_be[bus_rd] && bus_req.wdata == bus_wdata[bus_rd])))
        else stop_run($sformatf("FAIL %0t: bus request addr %08h be %h data %08h",
                                $time, $sampled(bus_req.addr), $sampled(bus_req.be),
                                $sampled(bus_req.wdata)));

    // Scratch window never leaks onto the bus
    bus_region: assert property (@(posedge clk) disable iff (rst)
        bus_valid |-> (bus_req.addr >= 32'(`LSU_SCRATCH_WORDS * 4)))
        else stop_run($sformatf("FAIL %0t: scratch address %08h on the bus",
                                $time, $sampled(bus_req.addr)));

    // Full buffer means at least a buffer's worth of requests still unresolved
    ready_level: assert property (@(posedge clk) disable iff (rst)
        !issue_ready |-> (6'(exp_wr - exp_rd) + 6'(exc_wr - exc_rd) >= `LSU_IN_DEPTH))
        else stop_run($sformatf("FAIL %0t: issue_ready low with only %0d requests pending",
                                $time, $sampled(6'(exp_wr - exp_rd) + 6'(exc_wr - exc_rd))));

    ////////////////////
    // Stimulus

    initial begin
        logic        r;
        logic [3:0]  w;
        logic [1:0]  off;
        logic [2:0]  fn;
        logic        ld;
        logic        fwd;
        lfsr        = 16'd48533;
        next_id     = '0;
        exp_wr      = '0;
        exc_wr      = '0;
        bus_wr      = '0;
        last_load   = '0;
        rst         <= 1'b1;
        issue_valid <= 1'b0;
        issue_req   <= '0;
        ack_delay   <= 2'd0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!wb.done && !exc.valid && !bus_valid)
            else stop_run("Outputs were not idle after reset");

        // Fill both windows with word stores
        for (int i = 0; i < 32; i++)
            issue_one(`LSU_FN_W, 1'b0, 1'b0, i[4], i[3:0], 2'd0, random_bits(32));

        // Every aligned offset with sign bits set in byte 0 and halfword 1
        for (int i = 0; i < 2; i++) begin
            issue_one(`LSU_FN_W, 1'b0, 1'b0, i[0], 4'd2, 2'd0, 32'h80F7_7F81);
            issue_one(`LSU_FN_W, 1'b1, 1'b0, i[0], 4'd2, 2'd0, 32'h0);
            for (int k = 0; k < 4; k++) begin
                issue_one(`LSU_FN_B, 1'b1, 1'b0, i[0], 4'd2, k[1:0], 32'h0);
                issue_one(`LSU_FN_BU, 1'b1, 1'b0, i[0], 4'd2, k[1:0], 32'h0);
            end
            for (int k = 0; k < 4; k += 2) begin
                issue_one(`LSU_FN_H, 1'b1, 1'b0, i[0], 4'd2, k[1:0], 32'h0);
                issue_one(`LSU_FN_HU, 1'b1, 1'b0, i[0], 4'd2, k[1:0], 32'h0);
            end
            // Misaligned halfword load and word store
            issue_one(`LSU_FN_H, 1'b1, 1'b0, i[0], 4'd4, 2'd1, 32'h0);
            issue_one(`LSU_FN_W, 1'b0, 1'b0, i[0], 4'd4, 2'd2, 32'h1234_5678);
        end

        // Forwarded stores checked by loading back
        issue_one(`LSU_FN_W, 1'b1, 1'b0, 1'b0, 4'd3, 2'd0, 32'h0);
        issue_one(`LSU_FN_W, 1'b0, 1'b1, 1'b1, 4'd5, 2'd0, 32'hDEAD_BEEF);
        issue_one(`LSU_FN_W, 1'b1, 1'b0, 1'b1, 4'd5, 2'd0, 32'h0);
        issue_one(`LSU_FN_B, 1'b0, 1'b1, 1'b0, 4'd6, 2'd1, 32'h0);
        issue_one(`LSU_FN_W, 1'b1, 1'b0, 1'b0, 4'd6, 2'd0, 32'h0);
        wait_drained();

        // Mixed random traffic
        for (int n = 0; n < 200; n++) begin
            r   = 1'(random_bits(1));
            w   = 4'(random_bits(4));
            off = 2'(random_bits(2));
            fn  = pick_fn(3'(random_bits(3)));
            ld  = 1'(random_bits(1));
            fwd = !ld && (random_bits(3) == 32'd0);
            issue_one(fn, ld, fwd, r, w, off, random_bits(32));
        end
        wait_drained();

        $display("No errors");
        $finish;
    end

endmodule

// File: flist.f
+incdir+src
src/lsu_pkg.sv
src/ls_fifo.sv
src/scratch_ram.sv
src/bus_master.sv
src/load_store_unit.sv
src/lsu_top.sv
bench/ext_mem_model.sv
bench/lsu_tb.sv

// File: src/bus_master.sv
////////////////////
// External bus sub-unit, one request outstanding at a time
// Holds the request level until acknowledged, returns read data a cycle later
////////////////////
`timescale 1ns/1ps

module bus_master (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::sub_request_t req,
    input  logic                  new_request,
    output logic                  ready,
    output logic                  data_valid,
    output logic [31:0]           data,
    output lsu_pkg::bus_req_t     bus_req,
    output logic                  bus_valid,
    input  logic                  bus_ack,
    input  logic [31:0]           bus_rdata
);

    logic [31:0] rdata_q;

    ////////////////////
    // Request capture

    // Payload latched on the request, held until ack
    always_ff @(posedge clk) begin
        if (new_request) begin
            bus_req.addr  <= {req.addr[31:2], 2'b00};
            bus_req.be    <= req.be;
            bus_req.wdata <= req.data;
            bus_req.write <= req.is_store;
        end
    end

    // Request level
    always_ff @(posedge clk) begin
        if (rst)
            bus_valid <= 1'b0;
        else if (new_request)
            bus_valid <= 1'b1;
        else if (bus_ack)
            bus_valid <= 1'b0;
    end

    // Busy from the cycle after new_request until the ack is seen
    assign ready = ~bus_valid;

    ////////////////////
    // Read return

    always_ff @(posedge clk) begin
        if (bus_valid && bus_ack && !bus_req.write)
            rdata_q <= bus_rdata;
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else
            data_valid <= bus_valid && bus_ack && !bus_req.write;
    end

    // Zero unless returning a load
    assign data = data_valid ? rdata_q : 32'h0;

    ////////////////////
    // Checks

    // Bus side must see a steady request until it acks
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        (bus_valid && !bus_ack) |=> (bus_valid && $stable(bus_req)))
        else $error("bus_req changed before ack");

endmodule

// File: src/load_store_unit.sv
////////////////////
// Load/store unit core: alignment, byte enables, routing and stalls
// Attribute queue keeps results in issue order for writeback
////////////////////
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_store_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::ls_request_t  in_req,
    input  logic                  in_valid,
    output logic                  in_pop,
    output lsu_pkg::sub_request_t sub_req,
    output logic                  ram_new_request,
    output logic                  bus_new_request,
    input  logic                  ram_ready,
    input  logic                  bus_ready,
    input  logic                  ram_data_valid,
    input  logic                  bus_data_valid,
    input  logic [31:0]           ram_data,
    input  logic [31:0]           bus_data,
    output lsu_pkg::wb_t          wb,
    output lsu_pkg::ls_exc_t      exc
);

    logic        misaligned;
    logic        to_bus;
    logic        target_ready;
    logic        unit_stall;
    logic        fwd_stall;
    logic        issue;
    logic [3:0]  be;
    logic [31:0] store_raw;
    logic [31:0] store_lanes;

    lsu_pkg::ls_attr_t attr_in;
    lsu_pkg::ls_attr_t attr_head;
    logic [$bits(lsu_pkg::ls_attr_t)-1:0] attr_bits;
    logic        attr_valid;
    logic        attr_full;
    logic        attr_pop;

    logic        load_complete;
    logic        store_complete;
    logic [31:0] muxed_data;
    logic [31:0] aligned_data;
    logic [31:0] final_data;
    logic [31:0] previous_load;

    ////////////////////
    // Issue decision

    // Halfword needs bit 0 clear, word needs both low bits clear
    always_comb begin
        case (in_req.fn3[1:0])
            2'b01:   misaligned = in_req.addr[0];
            2'b10:   misaligned = |in_req.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Anything outside the scratch window goes to the bus
    assign to_bus = (in_req.addr - `LSU_SCRATCH_BASE) >= 32'(`LSU_SCRATCH_WORDS * 4);
    assign target_ready = to_bus ? bus_ready : ram_ready;

    // Queue entries all share one unit, so the head tells which unit is busy
    assign unit_stall = attr_valid && (attr_head.bus_unit != to_bus);
    // Forwarded store needs the last load result settled
    assign fwd_stall  = in_req.is_store && in_req.forward && attr_valid;

    assign issue = in_valid && !misaligned && target_ready && !unit_stall
                   && !fwd_stall && !attr_full;
    assign in_pop = issue || (in_valid && misaligned);

    assign ram_new_request = issue && !to_bus;
    assign bus_new_request = issue && to_bus;

    ////////////////////
    // Store data path

    // Byte enables only on stores
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (in_req.fn3[1:0])
                2'b00:   be[i] = (in_req.addr[1:0] == 2'(i));
                2'b01:   be[i] = (in_req.addr[1] == i[1]);
                default: be[i] = 1'b1;
            endcase
            be[i] = be[i] && in_req.is_store;
        end
    end

    assign store_raw = in_req.forward ? previous_load : in_req.data;

    // Replicate across lanes, be picks the live ones
    always_comb begin
        case (in_req.fn3[1:0])
            2'b00:   store_lanes = {4{store_raw[7:0]}};
            2'b01:   store_lanes = {2{store_raw[15:0]}};
            default: store_lanes = store_raw;
        endcase
    end

    assign sub_req.addr     = in_req.addr;
    assign sub_req.be       = be;
    assign sub_req.data     = store_lanes;
    assign sub_req.is_store = in_req.is_store;

    ////////////////////
    // Attribute queue

    assign attr_in.fn3       = in_req.fn3;
    assign attr_in.byte_addr = in_req.addr[1:0];
    assign attr_in.id        = in_req.id;
    assign attr_in.is_store  = in_req.is_store;
    assign attr_in.bus_unit  = to_bus;

    ls_fifo #(
        .WIDTH ($bits(lsu_pkg::ls_attr_t)),
        .DEPTH (`LSU_ATTR_DEPTH)
    ) attr_queue (
        .clk      (clk),
        .rst      (rst),
        .push     (issue),
        .data_in  (attr_in),
        .pop      (attr_pop),
        .data_out (attr_bits),
        .valid    (attr_valid),
        .full     (attr_full)
    );

    assign attr_head = attr_bits;

    // Stores retire as soon as they reach the head
    assign store_complete = attr_valid && attr_head.is_store;
    assign load_complete  = attr_valid && !attr_head.is_store
                            && (attr_head.bus_unit ? bus_data_valid : ram_data_valid);
    assign attr_pop = load_complete || store_complete;

    ////////////////////
    // Load return

    assign muxed_data = ram_data | bus_data;

    // Halfword first, then byte within it
    always_comb begin
        aligned_data        = muxed_data;
        aligned_data[15:0]  = attr_head.byte_addr[1] ? muxed_data[31:16] : muxed_data[15:0];
        aligned_data[7:0]   = attr_head.byte_addr[0] ? aligned_data[15:8] : aligned_data[7:0];
    end

    always_comb begin
        case (attr_head.fn3)
            `LSU_FN_B:  final_data = {{24{aligned_data[7]}}, aligned_data[7:0]};
            `LSU_FN_H:  final_data = {{16{aligned_data[15]}}, aligned_data[15:0]};
            `LSU_FN_BU: final_data = {24'h0, aligned_data[7:0]};
            `LSU_FN_HU: final_data = {16'h0, aligned_data[15:0]};
            default:    final_data = aligned_data;
        endcase
    end

    // Source for forwarded stores
    always_ff @(posedge clk) begin
        if (load_complete)
            previous_load <= final_data;
    end

    assign wb.done = load_complete || store_complete;
    assign wb.id   = attr_head.id;
    assign wb.data = final_data;

    ////////////////////
    // Misalignment report

    // One pulse per dropped entry, fields follow the head
    always_ff @(posedge clk) begin
        if (rst) begin
            exc.valid <= 1'b0;
        end else begin
            exc.valid    <= in_valid && misaligned;
            exc.id       <= in_req.id;
            exc.addr     <= in_req.addr;
            exc.is_store <= in_req.is_store;
        end
    end

    ////////////////////
    // Checks

    // No unit switch while busy means returns never overlap
    a_one_return: assert property (@(posedge clk) disable iff (rst)
        !(ram_data_valid && bus_data_valid))
        else $error("both sub-units returned data in one cycle");

endmodule

// File: src/ls_fifo.sv
////////////////////
// Synchronous FIFO with an occupancy count
// Serves as the input buffer and as the attribute queue
////////////////////
`timescale 1ns/1ps

module ls_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    input  logic             pop,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Storage array
    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= data_in;
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head visible the cycle after its push
    assign data_out = mem[rd_ptr];
    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

    ////////////////////
    // Checks
    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("ls_fifo push while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else $error("ls_fifo pop while empty");

endmodule

// File: src/lsu_defs.svh
////////////////////
// Widths, depths, function codes and address map of the load/store unit
// Included by the package and by any module that sizes a buffer or the RAM
////////////////////
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Instruction id width
`define LSU_ID_W 4

// Input buffer depth
`define LSU_IN_DEPTH 4

// Attribute queue depth, longest sub-unit pipeline plus one
`define LSU_ATTR_DEPTH 2

// Function codes, low two bits give the access size
`define LSU_FN_B  3'b000
`define LSU_FN_H  3'b001
`define LSU_FN_W  3'b010
`define LSU_FN_BU 3'b100
`define LSU_FN_HU 3'b101

// Scratch RAM region, all other addresses go to the bus
`define LSU_SCRATCH_BASE  32'h0000_0000
`define LSU_SCRATCH_WORDS 256

`endif

// File: src/lsu_pkg.sv
////////////////////
// Packed structs shared by the load/store unit, its sub-units and the top
// Referenced by scoped names, widths come from the defines header
////////////////////
`include "lsu_defs.svh"

package lsu_pkg;

    // One instruction as issued by the core
    typedef struct packed {
        logic [2:0]              fn3;
        logic                    is_load;
        logic                    is_store;
        logic                    forward;
        logic [31:0]             addr;
        logic [31:0]             data;
        logic [`LSU_ID_W-1:0]    id;
    } ls_request_t;

    // Request seen by both sub-units
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] data;
        logic        is_store;
    } sub_request_t;

    // Attributes of a request in flight
    typedef struct packed {
        logic [2:0]              fn3;
        logic [1:0]              byte_addr;
        logic [`LSU_ID_W-1:0]    id;
        logic                    is_store;
        logic                    bus_unit;
    } ls_attr_t;

    // Result back to the core
    typedef struct packed {
        logic                    done;
        logic [`LSU_ID_W-1:0]    id;
        logic [31:0]             data;
    } wb_t;

    // Misaligned access report
    typedef struct packed {
        logic                    valid;
        logic [`LSU_ID_W-1:0]    id;
        logic [31:0]             addr;
        logic                    is_store;
    } ls_exc_t;

    // External bus request, addr is word aligned
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;
        logic [31:0] wdata;
        logic        write;
    } bus_req_t;

endpackage

// File: src/lsu_top.sv
////////////////////
// Load/store unit top level
// Input buffer, unit, scratch RAM and bus master wired to core and bus ports
////////////////////
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  lsu_pkg::ls_request_t issue_req,
    output logic                 issue_ready,
    output lsu_pkg::wb_t         wb,
    output lsu_pkg::ls_exc_t     exc,
    output lsu_pkg::bus_req_t    bus_req,
    output logic                 bus_valid,
    input  logic                 bus_ack,
    input  logic [31:0]          bus_rdata
);

    logic [$bits(lsu_pkg::ls_request_t)-1:0] in_bits;
    lsu_pkg::ls_request_t  in_head;
    logic                  in_valid;
    logic                  in_full;
    logic                  in_pop;
    lsu_pkg::sub_request_t sub_req;
    logic                  ram_new_request;
    logic                  bus_new_request;
    logic                  ram_ready;
    logic                  bus_ready;
    logic                  ram_data_valid;
    logic                  bus_data_valid;
    logic [31:0]           ram_data;
    logic [31:0]           bus_data;

    // Input buffer
    ls_fifo #(
        .WIDTH ($bits(lsu_pkg::ls_request_t)),
        .DEPTH (`LSU_IN_DEPTH)
    ) input_buffer (
        .clk      (clk),
        .rst      (rst),
        .push     (issue_valid),
        .data_in  (issue_req),
        .pop      (in_pop),
        .data_out (in_bits),
        .valid    (in_valid),
        .full     (in_full)
    );

    assign in_head     = in_bits;
    assign issue_ready = ~in_full;

    load_store_unit lsu (
        .clk             (clk),
        .rst             (rst),
        .in_req          (in_head),
        .in_valid        (in_valid),
        .in_pop          (in_pop),
        .sub_req         (sub_req),
        .ram_new_request (ram_new_request),
        .bus_new_request (bus_new_request),
        .ram_ready       (ram_ready),
        .bus_ready       (bus_ready),
        .ram_data_valid  (ram_data_valid),
        .bus_data_valid  (bus_data_valid),
        .ram_data        (ram_data),
        .bus_data        (bus_data),
        .wb              (wb),
        .exc             (exc)
    );

    // Sub-units share one request
    scratch_ram scratch (
        .clk         (clk),
        .rst         (rst),
        .req         (sub_req),
        .new_request (ram_new_request),
        .ready       (ram_ready),
        .data_valid  (ram_data_valid),
        .data        (ram_data)
    );

    bus_master bus (
        .clk         (clk),
        .rst         (rst),
        .req         (sub_req),
        .new_request (bus_new_request),
        .ready       (bus_ready),
        .data_valid  (bus_data_valid),
        .data        (bus_data),
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata)
    );

endmodule

// File: src/scratch_ram.sv
////////////////////
// Local data memory with byte enables
// Loads return one cycle after the request, always ready
////////////////////
`timescale 1ns/1ps
`include "lsu_defs.svh"

module scratch_ram (
    input  logic                  clk,
    input  logic                  rst,
    input  lsu_pkg::sub_request_t req,
    input  logic                  new_request,
    output logic                  ready,
    output logic                  data_valid,
    output logic [31:0]           data
);

    localparam int IDX_W = $clog2(`LSU_SCRATCH_WORDS);

    logic [31:0]      ram [`LSU_SCRATCH_WORDS];
    logic [31:0]      offset;
    logic [IDX_W-1:0] word_idx;
    logic [31:0]      rdata_q;

    // Word index inside the region
    assign offset   = req.addr - `LSU_SCRATCH_BASE;
    assign word_idx = offset[IDX_W+1:2];

    // Per-byte writes
    always_ff @(posedge clk) begin
        if (new_request && req.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (req.be[i])
                    ram[word_idx][i*8 +: 8] <= req.data[i*8 +: 8];
            end
        end
    end

    // Read word registered on any load request
    always_ff @(posedge clk) begin
        if (new_request && !req.is_store)
            rdata_q <= ram[word_idx];
    end

    always_ff @(posedge clk) begin
        if (rst)
            data_valid <= 1'b0;
        else
            data_valid <= new_request && !req.is_store;
    end

    // Zero when idle so the unit can OR the sub-unit outputs
    assign data  = data_valid ? rdata_q : 32'h0;
    assign ready = 1'b1;

endmodule
